// ==== hw/shift_settings.svh ====
// Shift unit settings
// Operand and shift counter widths shared by the RTL and the testbench

`ifndef SHIFT_SETTINGS_SVH
`define SHIFT_SETTINGS_SVH

// Width of the operand and result
`define SHIFT_XLEN 32

// Width of the shift down counter, enough for amounts 0 to 31
`define SHIFT_CNT_W 5

`endif

// ==== hw/shift_pkg.sv ====
// Shift unit package
// Opcodes, counter modes and sequencer states of the serial shift unit

`default_nettype none

package shift_pkg;

    // Shift operations on the operand register
    typedef enum logic [1:0] {
        SHIFT_SLL = 2'b00,
        SHIFT_SRL = 2'b01,
        SHIFT_SRA = 2'b10
    } shift_op_e;

    // Counter modes, same bit order as the microcode shift field
    // Bit 1 set means the counter is not loading
    typedef enum logic [1:0] {
        CNT_LOAD_BITS  = 2'b00,
        CNT_LOAD_BYTES = 2'b01,
        CNT_COUNT      = 2'b10,
        CNT_HOLD       = 2'b11
    } cnt_mode_e;

    // Sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE   = 2'b00,
        SEQ_RUN    = 2'b01,
        SEQ_FINISH = 2'b10
    } seq_state_e;

endpackage

`default_nettype wire

// ==== hw/shift_ctrl_if.sv ====
// Shift control interface
// Counter mode, load and step strobes between sequencer, counter and datapath

`timescale 1ns/10ps
`default_nettype none

interface shift_ctrl_if;

    // Mode of the shift counter for the current cycle
    shift_pkg::cnt_mode_e cnt_mode;

    // Datapath strobes, load captures operand and opcode, step shifts once
    logic load;
    logic step;

    // Counter reads zero while counting, combinational
    logic lastshift;

    // Same flag one cycle later
    logic rlastshift;

    // Sequencer side
    modport seq (
        output cnt_mode,
        output load,
        output step,
        input  lastshift,
        input  rlastshift
    );

    // Counter side
    modport cnt (
        input  cnt_mode,
        output lastshift,
        output rlastshift
    );

    // Datapath side only needs the two strobes
    modport dp (
        input load,
        input step
    );

endinterface

`default_nettype wire

// ==== hw/shift_counter.sv ====
// Shift counter
// 5-bit down counter that loads a bit or byte amount, counts down one per
// cycle and flags the last shift, plus a registered copy of that flag

`timescale 1ns/10ps
`default_nettype none

`include "shift_settings.svh"

module shift_counter (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire [`SHIFT_CNT_W-1:0] b,
    shift_ctrl_if.cnt              ctl
);

    // Current count
    logic [`SHIFT_CNT_W-1:0] cnt_q;
    logic [`SHIFT_CNT_W-1:0] cnt_d;

    // Decrement formed as count plus all ones on one extra bit
    // The top bit is set unless the count was zero, so a clear top bit is the borrow
    logic [`SHIFT_CNT_W:0] dec_sum;
    logic                  borrow;

    assign dec_sum = {1'b0, cnt_q} + {1'b0, {`SHIFT_CNT_W{1'b1}}};
    assign borrow  = ~dec_sum[`SHIFT_CNT_W];

    ////////////////////////////////////////////////////////////////////////////
    // Next count
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ctl.cnt_mode)
            shift_pkg::CNT_LOAD_BITS: begin
                cnt_d = b;
            end
            shift_pkg::CNT_LOAD_BYTES: begin
                // Byte amount is b[1:0] times eight, upper bits of b ignored
                cnt_d = {b[1:0], 3'b000};
            end
            shift_pkg::CNT_COUNT: begin
                // Wraps to all ones after zero, the sequencer holds it then
                cnt_d = dec_sum[`SHIFT_CNT_W-1:0];
            end
            default: begin
                cnt_d = cnt_q;
            end
        endcase
    end

    // The load cycle is never the last shift, so only count mode raises it
    assign ctl.lastshift = (ctl.cnt_mode == shift_pkg::CNT_COUNT) & borrow;

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q          <= '0;
            ctl.rlastshift <= 1'b0;
        end else begin
            cnt_q          <= cnt_d;
            ctl.rlastshift <= ctl.lastshift;
        end
    end

endmodule

`default_nettype wire

// ==== hw/shift_sequencer.sv ====
// Shift sequencer
// FSM that accepts a start, loads the counter, steps the datapath until the
// counter runs out and reports busy and a one-cycle done

`timescale 1ns/10ps
`default_nettype none

module shift_sequencer (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       start,
    input  wire       byte_mode,
    output logic      busy,
    output logic      done,
    shift_ctrl_if.seq ctl
);

    shift_pkg::seq_state_e state_q;
    shift_pkg::seq_state_e state_d;

    ////////////////////////////////////////////////////////////////////////////
    // Next state and strobes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Defaults keep the counter still and the datapath idle
        state_d      = state_q;
        ctl.cnt_mode = shift_pkg::CNT_HOLD;
        ctl.load     = 1'b0;
        ctl.step     = 1'b0;

        case (state_q)
            shift_pkg::SEQ_IDLE: begin
                // Start is only looked at here, so a start while busy is lost
                if (start) begin
                    ctl.load     = 1'b1;
                    ctl.cnt_mode = byte_mode ? shift_pkg::CNT_LOAD_BYTES
                                             : shift_pkg::CNT_LOAD_BITS;
                    state_d      = shift_pkg::SEQ_RUN;
                end
            end
            shift_pkg::SEQ_RUN: begin
                // One shift per cycle until the counter reads zero
                ctl.cnt_mode = shift_pkg::CNT_COUNT;
                ctl.step     = ~ctl.lastshift;
                if (ctl.lastshift) begin
                    state_d = shift_pkg::SEQ_FINISH;
                end
            end
            shift_pkg::SEQ_FINISH: begin
                // Registered last shift flag is out this cycle as done
                state_d = shift_pkg::SEQ_IDLE;
            end
            default: begin
                state_d = shift_pkg::SEQ_IDLE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= shift_pkg::SEQ_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Busy covers the count cycles and the done cycle
    assign busy = (state_q != shift_pkg::SEQ_IDLE);

    // Done pulses once, one cycle after the counter hit zero
    assign done = ctl.rlastshift;

endmodule

`default_nettype wire

// ==== hw/shift_datapath.sv ====
// Shift datapath
// Operand register that captures operand and opcode on load and shifts
// one bit per step, left logical, right logical or right arithmetic

`timescale 1ns/10ps
`default_nettype none

`include "shift_settings.svh"

module shift_datapath (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire [`SHIFT_XLEN-1:0] a,
    input  shift_pkg::shift_op_e  op,
    output logic [`SHIFT_XLEN-1:0] result,
    shift_ctrl_if.dp              ctl
);

    // Opcode of the running shift, kept stable while busy
    shift_pkg::shift_op_e op_q;

    // Operand being shifted
    logic [`SHIFT_XLEN-1:0] operand_q;
    logic [`SHIFT_XLEN-1:0] shifted;

    ////////////////////////////////////////////////////////////////////////////
    // One-bit shift
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op_q)
            shift_pkg::SHIFT_SLL: begin
                shifted = {operand_q[`SHIFT_XLEN-2:0], 1'b0};
            end
            shift_pkg::SHIFT_SRL: begin
                shifted = {1'b0, operand_q[`SHIFT_XLEN-1:1]};
            end
            shift_pkg::SHIFT_SRA: begin
                // Sign bit is repeated into the top
                shifted = {operand_q[`SHIFT_XLEN-1], operand_q[`SHIFT_XLEN-1:1]};
            end
            default: begin
                // Unused opcode leaves the operand unchanged
                shifted = operand_q;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= shift_pkg::SHIFT_SLL;
        end else if (ctl.load) begin
            op_q <= op;
        end
    end

    // Load and step never come in the same cycle
    always_ff @(posedge clk) begin
        if (ctl.load) begin
            operand_q <= a;
        end else if (ctl.step) begin
            operand_q <= shifted;
        end
    end

    // Result holds its value between shifts until the next load
    assign result = operand_q;

endmodule

`default_nettype wire

// ==== hw/shift_unit.sv ====
// Serial shift unit top level
// Shifts a 32-bit operand by one bit per clock under a 5-bit down counter,
// for a processor core without a barrel shifter

`timescale 1ns/10ps
`default_nettype none

`include "shift_settings.svh"

module shift_unit (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    start,
    input  shift_pkg::shift_op_e   op,
    input  wire                    byte_mode,
    input  wire [`SHIFT_XLEN-1:0]  a,
    input  wire [`SHIFT_CNT_W-1:0] b,
    output wire [`SHIFT_XLEN-1:0]  result,
    output wire                    busy,
    output wire                    done
);

    // Control strobes between the three blocks
    shift_ctrl_if ctl_if ();

    ////////////////////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////////////////////

    // Accepts start and paces the shift
    shift_sequencer u_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .byte_mode (byte_mode),
        .busy      (busy),
        .done      (done),
        .ctl       (ctl_if.seq)
    );

    // Holds the remaining shift amount
    shift_counter u_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .b     (b),
        .ctl   (ctl_if.cnt)
    );

    // Operand register
    shift_datapath u_datapath (
        .clk    (clk),
        .rst_n  (rst_n),
        .a      (a),
        .op     (op),
        .result (result),
        .ctl    (ctl_if.dp)
    );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
// Testbench clock and reset
// 40 ns clock, reset held low for the first three rising edges

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Release lands 2 ns after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== dv/shift_unit_tb.sv ====
// Serial shift unit testbench
// Random and directed shifts checked against a reference model, plus done timing

`timescale 1ns/10ps
`default_nettype none

`include "shift_settings.svh"

module shift_unit_tb;

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    shift_pkg::shift_op_e    op;
    logic                    byte_mode;
    logic [`SHIFT_XLEN-1:0]  a;
    logic [`SHIFT_CNT_W-1:0] b;
    wire  [`SHIFT_XLEN-1:0]  result;
    wire                     busy;
    wire                     done;

    // Expected result of every started shift in start order
    logic [`SHIFT_XLEN-1:0] exp_q[$];
    int errors;
    int tests;
    int failed;

    tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    shift_unit u_dut (
        .clk(clk), .rst_n(rst_n), .start(start), .op(op), .byte_mode(byte_mode),
        .a(a), .b(b), .result(result), .busy(busy), .done(done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Byte mode uses only b[1:0] scaled to whole bytes
    function automatic int shift_amount(
        input logic [`SHIFT_CNT_W-1:0] amt,
        input logic                    bytes
    );
        return bytes ? int'(amt[1:0]) * 8 : int'(amt);
    endfunction

    function automatic logic [`SHIFT_XLEN-1:0] ref_shift(
        input logic [`SHIFT_XLEN-1:0]  val,
        input shift_pkg::shift_op_e    opc,
        input logic [`SHIFT_CNT_W-1:0] amt,
        input logic                    bytes
    );
        int n;
        n = shift_amount(amt, bytes);
        case (opc)
            shift_pkg::SHIFT_SLL: return val << n;
            shift_pkg::SHIFT_SRL: return val >> n;
            default:              return $unsigned($signed(val) >>> n);
        endcase
    endfunction

    // Compares every done pulse with the oldest expected value
    always @(negedge clk) begin : compare
        logic [`SHIFT_XLEN-1:0] exp_val;
        if (done === 1'b1) begin
            assert (exp_q.size() > 0) else begin
                $display("done pulsed at %0t with no shift outstanding", $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                exp_val = exp_q.pop_front();
                assert (result === exp_val) else begin
                    $display("mismatch at %0t: result got %h expected %h",
                             $time, result, exp_val);
                    errors++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Starts one shift and follows busy and done until it ends
    // With poke set, a second start with other operands lands while busy
    task automatic run_shift(
        input logic [`SHIFT_XLEN-1:0]  val,
        input shift_pkg::shift_op_e    opc,
        input logic [`SHIFT_CNT_W-1:0] amt,
        input logic                    bytes,
        input logic                    poke
    );
        int n;
        int k;
        logic got;
        n   = shift_amount(amt, bytes);
        k   = 0;
        got = 1'b0;
        exp_q.push_back(ref_shift(val, opc, amt, bytes));
        @(posedge clk);
        #2;
        start     = 1'b1;
        a         = val;
        op        = opc;
        b         = amt;
        byte_mode = bytes;
        @(posedge clk);
        #2;
        start = poke;
        if (poke) begin
            a         = ~val;
            b         = ~amt;
            byte_mode = ~bytes;
            op = (opc == shift_pkg::SHIFT_SLL) ? shift_pkg::SHIFT_SRL : shift_pkg::SHIFT_SLL;
        end
        // k counts the cycles after the start cycle
        while (!got && k < 64) begin
            k++;
            @(negedge clk);
            assert (busy === 1'b1) else begin
                $display("mismatch at %0t: busy got %b expected 1", $time, busy);
                errors++;
            end
            got = (done === 1'b1);
            if (start) begin
                @(posedge clk);
                #2;
                start = 1'b0;
            end
        end
        assert (got) else begin
            $display("done never came, sequencer stuck in %s",
                     u_dut.u_sequencer.state_q.name());
            errors++;
            exp_q.delete();
        end
        if (got) begin
            assert (k == n + 2) else begin
                $display("mismatch at %0t: done cycle got %0d expected %0d", $time, k, n + 2);
                errors++;
            end
        end
        // One cycle later done has dropped and the unit is idle again
        @(negedge clk);
        assert (done === 1'b0 && busy === 1'b0) else begin
            $display("mismatch at %0t: done,busy got %b%b expected 00", $time, done, busy);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int first_err);
        tests++;
        if (errors == first_err) begin
            $display("test %-12s ok", name);
        end else begin
            failed++;
            $display("test %-12s failed with %0d errors", name, errors - first_err);
        end
    endtask

    initial begin : main
        int k;
        int first_err;
        errors    = 0;
        tests     = 0;
        failed    = 0;
        start     = 1'b0;
        op        = shift_pkg::SHIFT_SLL;
        byte_mode = 1'b0;
        a         = '0;
        b         = '0;
        void'($urandom(32'h4395));

        // Reset release, bounded like every other wait
        k = 0;
        while (rst_n !== 1'b1 && k < 10) begin
            @(posedge clk);
            k++;
        end
        assert (rst_n === 1'b1) else begin
            $display("reset was never released");
            errors++;
        end

        if (rst_n === 1'b1) begin
            first_err = errors;
            @(negedge clk);
            assert (busy === 1'b0 && done === 1'b0) else begin
                $display("mismatch at %0t: busy,done got %b%b expected 00",
                         $time, busy, done);
                errors++;
            end
            report_test("reset", first_err);

            // Negative operand under SRA first, then random bit amounts
            first_err = errors;
            run_shift(32'h8000_00f0, shift_pkg::SHIFT_SRA, 5'd7, 1'b0, 1'b0);
            for (int i = 0; i < 200; i++) begin
                run_shift($urandom, shift_pkg::shift_op_e'($urandom_range(0, 2)),
                          5'($urandom_range(0, 31)), 1'b0, 1'b0);
            end
            report_test("bit_mode", first_err);

            // Random b[4:2] must not change the byte amount
            first_err = errors;
            for (int sel = 0; sel < 4; sel++) begin
                for (int o = 0; o < 3; o++) begin
                    run_shift($urandom, shift_pkg::shift_op_e'(o),
                              {3'($urandom_range(0, 7)), 2'(sel)}, 1'b1, 1'b0);
                end
            end
            report_test("byte_mode", first_err);

            // Shortest and longest bit amounts
            first_err = errors;
            run_shift(32'hc3a5_0f81, shift_pkg::SHIFT_SRL, 5'd0, 1'b0, 1'b0);
            run_shift(32'h9e37_79b9, shift_pkg::SHIFT_SRA, 5'd31, 1'b0, 1'b0);
            report_test("timing", first_err);

            first_err = errors;
            run_shift(32'hdead_beef, shift_pkg::SHIFT_SLL, 5'd20, 1'b0, 1'b1);
            run_shift(32'h8123_4567, shift_pkg::SHIFT_SRA, 5'd0, 1'b0, 1'b1);
            report_test("busy_start", first_err);
        end

        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== shift_unit.f ====
+incdir+hw
hw/shift_pkg.sv
hw/shift_ctrl_if.sv
hw/shift_counter.sv
hw/shift_sequencer.sv
hw/shift_datapath.sv
hw/shift_unit.sv
dv/tb_clock_gen.sv
dv/shift_unit_tb.sv
